// ==== hw/cpu_pkg.sv ====
package cpu_pkg;

	typedef logic [31:0] word_t;
	typedef logic [4:0]  exc_code_t;
	typedef logic [4:0]  cp0_addr_t;

	localparam exc_code_t exc_int  = 5'd0;
	localparam exc_code_t exc_tlbl = 5'd2;
	localparam exc_code_t exc_tlbs = 5'd3;
	localparam exc_code_t exc_adel = 5'd4;
	localparam exc_code_t exc_ades = 5'd5;
	localparam exc_code_t exc_sys  = 5'd8;
	localparam exc_code_t exc_bp   = 5'd9;
	localparam exc_code_t exc_ri   = 5'd10;
	localparam exc_code_t exc_cpu  = 5'd11;
	localparam exc_code_t exc_ov   = 5'd12;

	localparam cp0_addr_t  cp0_badvaddr  = 5'd8;
	localparam cp0_addr_t  cp0_status    = 5'd12;
	localparam cp0_addr_t  cp0_cause     = 5'd13;
	localparam cp0_addr_t  cp0_epc       = 5'd14;
	localparam cp0_addr_t  cp0_ebase     = 5'd15;
	localparam logic [2:0] cp0_ebase_sel = 3'd1; // EBase sits at select 1 of register 15.
	localparam cp0_addr_t  cp0_errorepc  = 5'd30;

	localparam word_t vec_base_boot = 32'hbfc0_0200;
	localparam word_t vec_base_norm = 32'h8000_0000;
	localparam word_t off_refill    = 32'h0000_0000;
	localparam word_t off_general   = 32'h0000_0180;
	localparam word_t off_int_vec   = 32'h0000_0200;

	typedef struct packed {
		logic [8:0] rsvd_hi;   // CU, RP, FR, RE, MX and PX are not kept.
		logic       bev;
		logic [5:0] rsvd_mid;
		logic [7:0] im;
		logic [2:0] rsvd_lo;
		logic       um;
		logic       rsvd_r0;
		logic       erl;
		logic       exl;
		logic       ie;
	} status_t;

	typedef struct packed {
		logic       bd;
		logic       rsvd_ti;
		logic [1:0] ce;
		logic [3:0] rsvd_a;
		logic       iv;
		logic [6:0] rsvd_b;
		logic [7:0] ip;
		logic       rsvd_c;
		exc_code_t  exccode;
		logic [1:0] rsvd_d;
	} cause_t;

	typedef struct packed {
		status_t status;
		cause_t  cause;
		word_t   epc;
		word_t   error_epc;
		word_t   badvaddr;
		word_t   ebase;
	} cp0_regs_t;

	typedef struct packed {
		logic       we;
		cp0_addr_t  waddr;
		logic [2:0] sel;
		word_t      wdata;
	} cp0_wr_t;

	typedef struct packed {
		logic  valid;
		word_t pc;
		logic  delayslot;
		logic  is_priv_inst;
		word_t badvaddr;
	} lane_data_t;

	typedef struct packed {
		logic       occur;
		logic       eret;
		exc_code_t  code;
		logic [1:0] extra;
	} except_info_t;

	typedef struct packed {
		logic       flush;
		logic       alpha_taken;
		exc_code_t  code;
		logic       eret;
		logic       delayslot;
		word_t      cur_pc;
		word_t      jump_pc;
		logic [1:0] extra;
	} except_req_t;

	function automatic word_t masked_merge(input word_t old_val, input word_t new_val,
		input word_t mask);
		return (new_val & mask) | (old_val & ~mask);
	endfunction

	function automatic logic cp0_is_mapped(input cp0_addr_t addr, input logic [2:0] sel);
		if (addr == cp0_ebase)
			return sel == cp0_ebase_sel;
		return (sel == 3'd0) && (addr == cp0_badvaddr || addr == cp0_status ||
			addr == cp0_cause || addr == cp0_epc || addr == cp0_errorepc);
	endfunction

	// Applies one masked software write to a copy of the register set.
	function automatic cp0_regs_t cp0_apply_write(input cp0_regs_t regs, input cp0_wr_t wr,
		input word_t mask);
		cp0_regs_t res;
		res = regs;
		if (wr.we && wr.sel == 3'd0)
		begin
			case (wr.waddr)
				cp0_status:   res.status    = masked_merge(regs.status, wr.wdata, mask);
				cp0_cause:    res.cause     = masked_merge(regs.cause, wr.wdata, mask);
				cp0_epc:      res.epc       = masked_merge(regs.epc, wr.wdata, mask);
				cp0_errorepc: res.error_epc = masked_merge(regs.error_epc, wr.wdata, mask);
				cp0_badvaddr: res.badvaddr  = masked_merge(regs.badvaddr, wr.wdata, mask);
				default:      res           = regs;
			endcase
		end
		else if (wr.we && wr.waddr == cp0_ebase && wr.sel == cp0_ebase_sel)
			res.ebase = masked_merge(regs.ebase, wr.wdata, mask);
		return res;
	endfunction

endpackage

// ==== hw/cp0_write_mask.sv ====
`timescale 1ns/1ns

module cp0_write_mask (
	input  cpu_pkg::cp0_addr_t addr,
	input  logic [2:0]         sel,
	output cpu_pkg::word_t     mask
);

	cpu_pkg::status_t status_m;
	cpu_pkg::cause_t  cause_m;

	always_comb
	begin
		status_m         = '0;
		status_m.bev     = 1'b1;
		status_m.im      = '1;
		status_m.um      = 1'b1;
		status_m.erl     = 1'b1;
		status_m.exl     = 1'b1;
		status_m.ie      = 1'b1;
		cause_m          = '0;
		cause_m.iv       = 1'b1;
		cause_m.ip[1:0]  = 2'b11; // Only the software interrupt bits.
	end

	always_comb
	begin
		mask = '0;
		if (sel == 3'd0)
		begin
			case (addr)
				cpu_pkg::cp0_status:   mask = status_m;
				cpu_pkg::cp0_cause:    mask = cause_m;
				cpu_pkg::cp0_epc:      mask = '1;
				cpu_pkg::cp0_errorepc: mask = '1;
				default:               mask = '0; // BadVAddr is read only.
			endcase
		end
		else if (addr == cpu_pkg::cp0_ebase && sel == cpu_pkg::cp0_ebase_sel)
			mask = 32'h3fff_f000; // Exception base bits 29 to 12.
	end

endmodule

// ==== hw/cp0_forward.sv ====
`timescale 1ns/1ns

module cp0_forward (
	input  cpu_pkg::cp0_regs_t regs_q,
	input  cpu_pkg::cp0_wr_t   wb_cp0_wr,
	output cpu_pkg::cp0_regs_t regs_fwd
);

	cpu_pkg::word_t wmask;
	logic           mapped;

	cp0_write_mask u_mask (
		.addr (wb_cp0_wr.waddr),
		.sel  (wb_cp0_wr.sel),
		.mask (wmask)
	);

	// The write-back write has not reached the registers yet, so merge it here.
	always_comb
	begin
		regs_fwd = cpu_pkg::cp0_apply_write(regs_q, wb_cp0_wr, wmask);
	end

	assign mapped = cpu_pkg::cp0_is_mapped(wb_cp0_wr.waddr, wb_cp0_wr.sel);

	// Decode in the write-back stage must only produce implemented registers.
	always_comb
	begin
		if (wb_cp0_wr.we)
			assert (mapped)
			else $error("CP0 write to unmapped register %0d sel %0d",
				wb_cp0_wr.waddr, wb_cp0_wr.sel);
	end

endmodule

// ==== hw/lane_except_check.sv ====
`timescale 1ns/1ns

module lane_except_check (
	input  logic                  clk,
	input  logic                  rst_n,
	input  cpu_pkg::lane_data_t   lane,
	input  cpu_pkg::except_info_t exc_in,
	input  cpu_pkg::cp0_regs_t    regs,
	output cpu_pkg::except_info_t exc_out
);

	logic user_mode;

	assign user_mode = regs.status.um && !regs.status.exl && !regs.status.erl;

	always_comb
	begin
		exc_out = '0;
		if (!lane.valid)
			exc_out = '0; // A bubble never raises anything.
		else if (exc_in.occur && !exc_in.eret)
			exc_out = exc_in; // Fetch and decode faults came first.
		else if (user_mode && lane.is_priv_inst)
		begin
			exc_out.occur = 1'b1;
			exc_out.eret  = 1'b0;
			exc_out.code  = cpu_pkg::exc_cpu;
			exc_out.extra = 2'd0; // CP0 is unusable, so Cause.ce is 0.
		end
		else
			exc_out = exc_in;
	end

	// Upstream stages must clear their exception flags on bubbles too.
	a_occur_valid: assert property (@(posedge clk) disable iff (!rst_n)
		exc_in.occur |-> lane.valid);

endmodule

// ==== hw/except_arbiter.sv ====
`timescale 1ns/1ns

module except_arbiter (
	input  logic                  clk,
	input  logic                  rst_n,
	input  cpu_pkg::lane_data_t   lane_a,
	input  cpu_pkg::lane_data_t   lane_b,
	input  cpu_pkg::except_info_t exc_a,
	input  cpu_pkg::except_info_t exc_b,
	input  cpu_pkg::cp0_regs_t    regs,
	output cpu_pkg::except_req_t  req
);

	logic                  int_pending;
	logic                  alpha;
	cpu_pkg::except_info_t chosen;
	cpu_pkg::word_t        base;
	cpu_pkg::word_t        offset;

	assign int_pending = regs.status.ie && !regs.status.exl && !regs.status.erl &&
		((regs.cause.ip & regs.status.im) != 8'b0);

	// Interrupts are taken on the older lane.
	always_comb
	begin
		if (int_pending)
		begin
			chosen.occur = 1'b1;
			chosen.eret  = 1'b0;
			chosen.code  = cpu_pkg::exc_int;
			chosen.extra = 2'd0;
			alpha        = 1'b1;
		end
		else if (exc_a.occur)
		begin
			chosen = exc_a;
			alpha  = 1'b1;
		end
		else
		begin
			chosen = exc_b;
			alpha  = 1'b0;
		end
	end

	always_comb
	begin
		if (regs.status.bev)
			base = cpu_pkg::vec_base_boot;
		else
			base = {regs.ebase[31:12], 12'h000};
	end

	always_comb
	begin
		offset = cpu_pkg::off_general; // Nested exceptions always use the general vector.
		if (!regs.status.exl)
		begin
			if (chosen.code == cpu_pkg::exc_tlbl || chosen.code == cpu_pkg::exc_tlbs)
				offset = cpu_pkg::off_refill;
			else if (chosen.code == cpu_pkg::exc_int && regs.cause.iv)
				offset = cpu_pkg::off_int_vec;
		end
	end

	always_comb
	begin
		req = '0;
		if (chosen.occur)
		begin
			req.flush       = 1'b1;
			req.alpha_taken = alpha;
			req.code        = chosen.code;
			req.eret        = chosen.eret;
			req.extra       = chosen.extra;
			req.cur_pc      = alpha ? lane_a.pc : lane_b.pc;
			req.delayslot   = alpha ? lane_a.delayslot : lane_b.delayslot;
			if (chosen.eret)
				req.jump_pc = regs.status.erl ? regs.error_epc : regs.epc;
			else
				req.jump_pc = base + offset;
		end
	end

	// An ERET outside exception level comes from a plain instruction and carries no code.
	a_eret_code: assert property (@(posedge clk) disable iff (!rst_n)
		(req.flush && req.eret && !regs.status.exl && !regs.status.erl) |->
		(req.code == '0));

endmodule

// ==== hw/cp0_state.sv ====
`timescale 1ns/1ns

module cp0_state (
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic [5:0]           hw_int,
	input  cpu_pkg::cp0_wr_t     wb_cp0_wr,
	input  cpu_pkg::except_req_t req,
	output cpu_pkg::cp0_regs_t   regs_q
);

	cpu_pkg::word_t     wmask;
	cpu_pkg::cp0_regs_t regs_sw;
	cpu_pkg::cp0_regs_t regs_d;

	cp0_write_mask u_mask (
		.addr (wb_cp0_wr.waddr),
		.sel  (wb_cp0_wr.sel),
		.mask (wmask)
	);

	assign regs_sw = cpu_pkg::cp0_apply_write(regs_q, wb_cp0_wr, wmask);

	// Exception side effects are applied over the software write.
	always_comb
	begin
		regs_d = regs_sw;
		if (req.flush && req.eret)
		begin
			if (regs_sw.status.erl)
				regs_d.status.erl = 1'b0;
			else
				regs_d.status.exl = 1'b0;
		end
		else if (req.flush)
		begin
			if (!regs_sw.status.exl)
			begin
				regs_d.epc        = req.delayslot ? req.cur_pc - 32'd4 : req.cur_pc;
				regs_d.cause.bd   = req.delayslot;
				regs_d.status.exl = 1'b1;
			end
			regs_d.cause.exccode = req.code;
			regs_d.cause.ce      = req.extra;
		end
		regs_d.cause.ip[7:2] = hw_int; // Hardware lines are resampled every cycle.
	end

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			regs_q            <= '0;
			regs_q.status.bev <= 1'b1;
			regs_q.status.erl <= 1'b1;
			regs_q.ebase      <= cpu_pkg::vec_base_norm;
		end
		else
			regs_q <= regs_d;
	end

	// Handlers rely on EXL masking interrupts from the first instruction on.
	a_exl_after_flush: assert property (@(posedge clk) disable iff (!rst_n)
		(req.flush && !req.eret) |=> regs_q.status.exl);

endmodule

// ==== hw/except_unit_top.sv ====
`timescale 1ns/1ns

module except_unit_top (
	input  logic                  clk,
	input  logic                  rst_n,
	input  cpu_pkg::lane_data_t   data_a,
	input  cpu_pkg::lane_data_t   data_b,
	input  cpu_pkg::except_info_t except_a,
	input  cpu_pkg::except_info_t except_b,
	input  logic [5:0]            hw_int,
	input  cpu_pkg::cp0_wr_t      wb_cp0_wr,
	input  cpu_pkg::cp0_addr_t    rd_addr,
	input  logic [2:0]            rd_sel,
	output cpu_pkg::except_req_t  except_req,
	output cpu_pkg::word_t        rd_data
);

	cpu_pkg::cp0_regs_t    regs_q;
	cpu_pkg::cp0_regs_t    regs_fwd;
	cpu_pkg::except_info_t lane_a_exc;
	cpu_pkg::except_info_t lane_b_exc;

	cp0_state u_cp0_state (
		.clk       (clk),
		.rst_n     (rst_n),
		.hw_int    (hw_int),
		.wb_cp0_wr (wb_cp0_wr),
		.req       (except_req),
		.regs_q    (regs_q)
	);

	cp0_forward u_cp0_forward (
		.regs_q    (regs_q),
		.wb_cp0_wr (wb_cp0_wr),
		.regs_fwd  (regs_fwd)
	);

	lane_except_check u_lane_a (
		.clk     (clk),
		.rst_n   (rst_n),
		.lane    (data_a),
		.exc_in  (except_a),
		.regs    (regs_fwd),
		.exc_out (lane_a_exc)
	);

	lane_except_check u_lane_b (
		.clk     (clk),
		.rst_n   (rst_n),
		.lane    (data_b),
		.exc_in  (except_b),
		.regs    (regs_fwd),
		.exc_out (lane_b_exc)
	);

	except_arbiter u_arbiter (
		.clk    (clk),
		.rst_n  (rst_n),
		.lane_a (data_a),
		.lane_b (data_b),
		.exc_a  (lane_a_exc),
		.exc_b  (lane_b_exc),
		.regs   (regs_fwd),
		.req    (except_req)
	);

	always_comb
	begin
		rd_data = '0;
		if (rd_sel == 3'd0)
		begin
			case (rd_addr)
				cpu_pkg::cp0_status:   rd_data = regs_fwd.status;
				cpu_pkg::cp0_cause:    rd_data = regs_fwd.cause;
				cpu_pkg::cp0_epc:      rd_data = regs_fwd.epc;
				cpu_pkg::cp0_errorepc: rd_data = regs_fwd.error_epc;
				cpu_pkg::cp0_badvaddr: rd_data = regs_fwd.badvaddr;
				default:               rd_data = '0;
			endcase
		end
		else if (rd_addr == cpu_pkg::cp0_ebase && rd_sel == cpu_pkg::cp0_ebase_sel)
			rd_data = regs_fwd.ebase;
	end

endmodule

// ==== sim/except_tb.sv ====
`timescale 1ns/1ns

module except_tb;

	typedef struct packed {
		logic                  rnd;
		cpu_pkg::lane_data_t   a;
		cpu_pkg::lane_data_t   b;
		cpu_pkg::except_info_t ea;
		cpu_pkg::except_info_t eb;
		logic [5:0]            hw;
		cpu_pkg::cp0_wr_t      wr;
		logic                  flush;
		logic                  alpha;
		cpu_pkg::exc_code_t    code;
		cpu_pkg::word_t        cur;
		cpu_pkg::word_t        jump;
		logic                  eret;
		logic                  ds;
		logic [1:0]            extra;
		cpu_pkg::cp0_addr_t    rd_addr;
		logic [2:0]            rd_sel;
		cpu_pkg::word_t        rd_exp;
	} vec_t;

	logic                  clk;
	logic                  rst_n;
	cpu_pkg::lane_data_t   data_a;
	cpu_pkg::lane_data_t   data_b;
	cpu_pkg::except_info_t except_a;
	cpu_pkg::except_info_t except_b;
	logic [5:0]            hw_int;
	cpu_pkg::cp0_wr_t      wb_cp0_wr;
	cpu_pkg::cp0_addr_t    rd_addr;
	logic [2:0]            rd_sel;
	cpu_pkg::except_req_t  except_req;
	cpu_pkg::word_t        rd_data;

	vec_t  vecs[$];
	string names[$];
	int    num_vec = 0;
	logic  loaded = 1'b0;
	int    errors = 0;

	except_unit_top DUT (
		.clk        (clk),
		.rst_n      (rst_n),
		.data_a     (data_a),
		.data_b     (data_b),
		.except_a   (except_a),
		.except_b   (except_b),
		.hw_int     (hw_int),
		.wb_cp0_wr  (wb_cp0_wr),
		.rd_addr    (rd_addr),
		.rd_sel     (rd_sel),
		.except_req (except_req),
		.rd_data    (rd_data)
	);

	always #5 clk = ~clk;

	task automatic report_mismatch(input string test, input string field,
		input logic [31:0] exp_val, input logic [31:0] act_val);
		$display("** Error %0s %0s expected %08h actual %08h", test, field, exp_val, act_val);
		errors++;
	endtask

	// Random PCs are word aligned; the chosen lane then fixes cur_pc and EPC.
	task automatic load_vectors();
		int          fd;
		int          n;
		int          k;
		string       line;
		string       name;
		logic [31:0] f[28];
		vec_t        v;
		fd = $fopen("sim/except_input.txt", "r");
		if (fd == 0)
		begin
			$display("Cannot open the vector file sim/except_input.txt.");
			return;
		end
		while (!$feof(fd))
		begin
			if ($fscanf(fd, "%s", name) != 1)
				break;
			if (name.getc(0) == "#")
			begin
				void'($fgets(line, fd)); // Rest of a column note.
				continue;
			end
			n = 0;
			for (k = 0; k < 28; k++)
				n += $fscanf(fd, "%h", f[k]);
			if (n != 28)
			begin
				$display("Malformed vector line for test %0s.", name);
				errors++;
				break;
			end
			v = '0;
			v.rnd = f[0][0];
			v.a.valid = f[1][0];
			v.a.pc = f[2];
			v.a.delayslot = f[3][0];
			v.a.is_priv_inst = f[4][0];
			v.ea.occur = f[5][0];
			v.ea.eret = f[6][0];
			v.ea.code = f[7][4:0];
			v.b.valid = f[8][0];
			v.b.pc = f[9];
			v.b.delayslot = f[10][0];
			v.b.is_priv_inst = f[11][0];
			v.eb.occur = f[12][0];
			v.eb.eret = f[13][0];
			v.eb.code = f[14][4:0];
			v.hw = f[15][5:0];
			v.wr.we = f[16][0];
			v.wr.waddr = f[17][4:0];
			v.wr.sel = f[18][2:0];
			v.wr.wdata = f[19];
			v.flush = f[20][0];
			v.alpha = f[21][0];
			v.code = f[22][4:0];
			v.cur = f[23];
			v.jump = f[24];
			v.rd_addr = f[25][4:0];
			v.rd_sel = f[26][2:0];
			v.rd_exp = f[27];
			if (v.flush)
			begin
				v.eret  = v.alpha ? v.ea.eret : v.eb.eret;
				v.ds    = v.alpha ? v.a.delayslot : v.b.delayslot;
				v.extra = v.alpha ? v.ea.extra : v.eb.extra;
			end
			if (v.rnd)
			begin
				v.a.pc = $urandom & 32'hffff_fffc;
				v.b.pc = $urandom & 32'hffff_fffc;
				if (v.flush)
					v.cur = v.alpha ? v.a.pc : v.b.pc;
				if (v.rd_addr == cpu_pkg::cp0_epc)
					v.rd_exp = v.cur - (v.ds ? 4 : 0);
			end
			vecs.push_back(v);
			names.push_back(name);
		end
		$fclose(fd);
	endtask

	initial
	begin
		wait (loaded);
		#(num_vec * 2 * 10 + 200);
		$display("Timeout: the run did not finish within %0d vectors of time.", num_vec);
		$display("TB FAILED");
		$finish;
	end

	initial
	begin
		int ok;
		clk = 1'b0;
		rst_n = 1'b0;
		data_a = '0;
		data_b = '0;
		except_a = '0;
		except_b = '0;
		hw_int = '0;
		wb_cp0_wr = '0;
		rd_addr = '0;
		rd_sel = '0;
		void'($urandom(32'h496d_c56e));
		load_vectors();
		num_vec = vecs.size();
		if (num_vec == 0)
		begin
			$display("No test vectors were loaded.");
			errors++;
		end
		loaded = 1'b1;
		repeat (4) @(posedge clk);
		#1 rst_n = 1'b1;
		foreach (vecs[i])
		begin
			ok = errors;
			@(posedge clk);
			#1;
			data_a = vecs[i].a;
			data_b = vecs[i].b;
			except_a = vecs[i].ea;
			except_b = vecs[i].eb;
			hw_int = vecs[i].hw;
			wb_cp0_wr = vecs[i].wr;
			rd_addr = '0;
			rd_sel = '0;
			#8;
			if (except_req.flush !== vecs[i].flush)
				report_mismatch(names[i], "flush", vecs[i].flush, except_req.flush);
			if (except_req.alpha_taken !== vecs[i].alpha)
				report_mismatch(names[i], "alpha_taken", vecs[i].alpha, except_req.alpha_taken);
			if (except_req.code !== vecs[i].code)
				report_mismatch(names[i], "code", vecs[i].code, except_req.code);
			if (except_req.eret !== vecs[i].eret)
				report_mismatch(names[i], "eret", vecs[i].eret, except_req.eret);
			if (except_req.delayslot !== vecs[i].ds)
				report_mismatch(names[i], "delayslot", vecs[i].ds, except_req.delayslot);
			if (except_req.extra !== vecs[i].extra)
				report_mismatch(names[i], "extra", vecs[i].extra, except_req.extra);
			if (except_req.cur_pc !== vecs[i].cur)
				report_mismatch(names[i], "cur_pc", vecs[i].cur, except_req.cur_pc);
			if (except_req.jump_pc !== vecs[i].jump)
				report_mismatch(names[i], "jump_pc", vecs[i].jump, except_req.jump_pc);
			@(posedge clk);
			#1;
			data_a = '0; // The readback cycle retires nothing.
			data_b = '0;
			except_a = '0;
			except_b = '0;
			wb_cp0_wr = '0;
			rd_addr = vecs[i].rd_addr;
			rd_sel = vecs[i].rd_sel;
			#8;
			if (vecs[i].rd_addr != 5'h1f && rd_data !== vecs[i].rd_exp)
				report_mismatch(names[i], "rd_data", vecs[i].rd_exp, rd_data);
			$display("%0s: %0s", names[i], (errors == ok) ? "ok" : "mismatch");
		end
		$display("Tests run %0d, errors %0d", num_vec, errors);
		if (errors == 0)
			$display("TB PASSED");
		else
			$display("TB FAILED");
		$finish;
	end

endmodule

// ==== sim/except_input.txt ====
# name rnd | lane a: valid pc ds priv occ eret code | lane b: same | hw_int | we waddr sel wdata
# | expected: flush alpha code cur_pc jump_pc | read next cycle: addr sel value (addr 1f skips it)
reset_status 0 0 0 0 0 0 0 00 0 0 0 0 0 0 00 00 0 00 0 0 0 0 00 0 0 0c 0 00400004
both_lanes 1 1 0 1 0 1 0 0a 1 0 0 0 1 0 08 00 0 00 0 0 1 1 0a 0 bfc00380 0e 0 0
exl_set 0 0 0 0 0 0 0 00 0 0 0 0 0 0 00 00 0 00 0 0 0 0 00 0 0 0c 0 00400006
priv_lane_b 0 1 1000 0 0 0 0 00 1 1004 0 1 0 0 00 00 1 0c 0 00400010 1 0 0b 1004 bfc00380 0d 0 0000002c
priv_kernel 0 0 0 0 0 0 0 00 1 1008 0 1 0 0 00 00 0 00 0 0 0 0 00 0 0 0c 0 00400012
cause_iv 0 0 0 0 0 0 0 00 0 0 0 0 0 0 00 01 1 0d 0 00800000 0 0 00 0 0 0d 0 0080042c
int_wins 1 1 0 0 0 1 0 0a 0 0 0 0 0 0 00 01 1 0c 0 0000ff01 1 1 00 0 80000200 0c 0 0000ff03
eret_epc 0 1 2000 0 0 1 1 00 0 0 0 0 0 0 00 00 1 0e 0 00004440 1 1 00 2000 00004440 0c 0 0000ff01
cause_mask 0 0 0 0 0 0 0 00 0 0 0 0 0 0 00 15 1 0d 0 ffffffff 1 1 00 0 80000200 0d 0 00805700

// ==== vlog.f ====
hw/cpu_pkg.sv
hw/cp0_write_mask.sv
hw/cp0_forward.sv
hw/lane_except_check.sv
hw/except_arbiter.sv
hw/cp0_state.sv
hw/except_unit_top.sv
sim/except_tb.sv

// ==== run_sim.sh ====
#!/bin/bash
# Build and run the exception unit testbench with Verilator.
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --assert -Wno-fatal --top-module except_tb -f vlog.f \
	-Mdir obj_dir -o sim_except > build.log 2>&1 \
	&& ./obj_dir/sim_except > sim.log 2>&1 \
	|| { cat build.log sim.log 2>/dev/null; echo "Build or run failed"; exit 1; }
cat sim.log
grep -q "TB FAILED" sim.log && { echo "Simulation failed"; exit 1; } || echo "Simulation passed"
